// File: src/mont_pkg.sv
package mont_pkg;

    // operand width in bits
    // the datapath also works at 1024
    localparam int OP_WIDTH = 256;

    // room for acc + 3B + 3M before the shift, and the sign of acc - M
    localparam int ACC_WIDTH = OP_WIDTH + 3;

    // radix-4 loop takes two bits of A per iteration
    localparam int NUM_DIGITS = OP_WIDTH / 2;

    localparam int DIGIT_CNT_WIDTH = $clog2(NUM_DIGITS + 1);

    // loop phase codes
    localparam logic [2:0] PH_IDLE   = 3'd0;
    localparam logic [2:0] PH_PRE_B  = 3'd1;
    localparam logic [2:0] PH_PRE_M  = 3'd2;
    localparam logic [2:0] PH_ADD_B  = 3'd3;
    localparam logic [2:0] PH_ADD_M  = 3'd4;
    localparam logic [2:0] PH_REDUCE = 3'd5;
    localparam logic [2:0] PH_DONE   = 3'd6;

endpackage

// File: src/mont_ctrl.sv
`timescale 1ns/1ps

module mont_ctrl (
    input  logic       clk,
    input  logic       resetn,
    input  logic       start,
    input  logic [1:0] m_low,
    input  logic [1:0] digit,
    input  logic [1:0] acc_low,
    output logic [2:0] phase,
    output logic [1:0] q_digit,
    output logic       busy,
    output logic       done
);
    import mont_pkg::*;

    logic [2:0]                 phase_next;
    logic [DIGIT_CNT_WIDTH-1:0] digit_cnt;
    logic                       last_digit;
    logic [3:0]                 qm_product;
    logic [1:0]                 quotient;

    // m is odd so m_low is its own inverse mod 4
    // q = -(acc * m) mod 4 clears the two low bits of acc + q*M
    assign qm_product = acc_low * m_low;
    assign quotient   = 2'd0 - qm_product[1:0];

    // multiple select seen by the accumulator
    // A digit while adding B, quotient while adding M
    always_comb begin
        case (phase)
            PH_ADD_B: q_digit = digit;
            PH_ADD_M: q_digit = quotient;
            default:  q_digit = 2'd0;
        endcase
    end

    assign last_digit = (digit_cnt == DIGIT_CNT_WIDTH'(NUM_DIGITS - 1));

    // phase sequencing with fixed latency
    always_comb begin
        phase_next = phase;
        case (phase)
            PH_IDLE: begin
                if (start) begin
                    phase_next = PH_PRE_B;
                end
            end
            PH_PRE_B: begin
                phase_next = PH_PRE_M;
            end
            PH_PRE_M: begin
                phase_next = PH_ADD_B;
            end
            PH_ADD_B: begin
                phase_next = PH_ADD_M;
            end
            PH_ADD_M: begin
                if (last_digit) begin
                    phase_next = PH_REDUCE;
                end else begin
                    phase_next = PH_ADD_B;
                end
            end
            PH_REDUCE: begin
                phase_next = PH_DONE;
            end
            PH_DONE: begin
                phase_next = PH_IDLE;
            end
            default: begin
                phase_next = PH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            phase     <= PH_IDLE;
            busy      <= 1'b0;
            done      <= 1'b0;
            digit_cnt <= '0;
        end else begin
            phase <= phase_next;
            // busy drops on the same edge as done
            busy  <= (phase_next != PH_IDLE);
            done  <= (phase_next == PH_DONE);

            if (phase == PH_PRE_M) begin
                digit_cnt <= '0;
            end else if (phase == PH_ADD_M) begin
                digit_cnt <= digit_cnt + 1'b1;
            end
        end
    end

endmodule

// File: src/multiple_precompute.sv
`timescale 1ns/1ps

module multiple_precompute (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic [2:0]                     phase,
    input  logic [mont_pkg::OP_WIDTH-1:0]  b,
    input  logic [mont_pkg::OP_WIDTH-1:0]  m,
    output logic [mont_pkg::ACC_WIDTH-2:0] b3,
    output logic [mont_pkg::ACC_WIDTH-2:0] m3
);
    import mont_pkg::*;

    logic [OP_WIDTH-1:0]  src;
    logic [ACC_WIDTH-2:0] triple;

    // one adder shared by both precompute cycles
    assign src = (phase == PH_PRE_M) ? m : b;

    // 2x + x
    assign triple = {1'b0, src, 1'b0} + {2'b00, src};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            b3 <= '0;
            m3 <= '0;
        end else begin
            if (phase == PH_PRE_B) begin
                b3 <= triple;
            end
            if (phase == PH_PRE_M) begin
                m3 <= triple;
            end
        end
    end

endmodule

// File: src/multiplier_shifter.sv
`timescale 1ns/1ps

module multiplier_shifter (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic [2:0]                    phase,
    input  logic [mont_pkg::OP_WIDTH-1:0] a,
    output logic [1:0]                    digit
);
    import mont_pkg::*;

    logic [OP_WIDTH-1:0] a_shift;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            a_shift <= '0;
        end else if (phase == PH_PRE_B) begin
            a_shift <= a;
        end else if (phase == PH_ADD_M) begin
            // next digit once the M add is done
            a_shift <= a_shift >> 2;
        end
    end

    assign digit = a_shift[1:0];

endmodule

// File: src/mont_accumulator.sv
`timescale 1ns/1ps

module mont_accumulator (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic [2:0]                     phase,
    input  logic [1:0]                     digit,
    input  logic [1:0]                     q_digit,
    input  logic [mont_pkg::OP_WIDTH-1:0]  b,
    input  logic [mont_pkg::OP_WIDTH-1:0]  m,
    input  logic [mont_pkg::ACC_WIDTH-2:0] b3,
    input  logic [mont_pkg::ACC_WIDTH-2:0] m3,
    output logic [1:0]                     acc_low,
    output logic [mont_pkg::OP_WIDTH-1:0]  result
);
    import mont_pkg::*;

    logic [ACC_WIDTH-1:0] acc;
    logic [ACC_WIDTH-1:0] addend;
    logic [ACC_WIDTH-1:0] sum;
    logic [ACC_WIDTH-1:0] diff;
    logic [ACC_WIDTH-1:0] b_ext;
    logic [ACC_WIDTH-1:0] m_ext;

    assign b_ext = {3'b000, b};
    assign m_ext = {3'b000, m};

    // multiple of B by the A digit, multiple of M by the quotient
    always_comb begin
        addend = '0;
        if (phase == PH_ADD_B) begin
            case (digit)
                2'd1:    addend = b_ext;
                2'd2:    addend = b_ext << 1;
                2'd3:    addend = {1'b0, b3};
                default: addend = '0;
            endcase
        end else if (phase == PH_ADD_M) begin
            case (q_digit)
                2'd1:    addend = m_ext;
                2'd2:    addend = m_ext << 1;
                2'd3:    addend = {1'b0, m3};
                default: addend = '0;
            endcase
        end
    end

    assign sum = acc + addend;

    // acc stays below 2M, so a single subtraction is enough
    assign diff = acc - m_ext;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            acc <= '0;
        end else begin
            case (phase)
                PH_PRE_B: acc <= '0;
                PH_ADD_B: acc <= sum;
                // low two bits are zero here by choice of q
                PH_ADD_M: acc <= sum >> 2;
                default:  acc <= acc;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == PH_REDUCE) begin
            // sign bit set means acc < M
            if (diff[ACC_WIDTH-1]) begin
                result <= acc[OP_WIDTH-1:0];
            end else begin
                result <= diff[OP_WIDTH-1:0];
            end
        end
    end

    assign acc_low = acc[1:0];

endmodule

// File: src/montgomery_top.sv
`timescale 1ns/1ps

module montgomery_top (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          start,
    input  logic [mont_pkg::OP_WIDTH-1:0] a,
    input  logic [mont_pkg::OP_WIDTH-1:0] b,
    input  logic [mont_pkg::OP_WIDTH-1:0] m,
    output logic [mont_pkg::OP_WIDTH-1:0] result,
    output logic                          busy,
    output logic                          done
);
    import mont_pkg::*;

    logic [2:0]           phase;
    logic [1:0]           q_digit;
    logic [1:0]           digit;
    logic [1:0]           acc_low;
    logic [ACC_WIDTH-2:0] b3;
    logic [ACC_WIDTH-2:0] m3;

    mont_ctrl u_ctrl (
        .clk     (clk),
        .resetn  (resetn),
        .start   (start),
        .m_low   (m[1:0]),
        .digit   (digit),
        .acc_low (acc_low),
        .phase   (phase),
        .q_digit (q_digit),
        .busy    (busy),
        .done    (done)
    );

    multiple_precompute u_precompute (
        .clk    (clk),
        .resetn (resetn),
        .phase  (phase),
        .b      (b),
        .m      (m),
        .b3     (b3),
        .m3     (m3)
    );

    multiplier_shifter u_shifter (
        .clk    (clk),
        .resetn (resetn),
        .phase  (phase),
        .a      (a),
        .digit  (digit)
    );

    mont_accumulator u_acc (
        .clk     (clk),
        .resetn  (resetn),
        .phase   (phase),
        .digit   (digit),
        .q_digit (q_digit),
        .b       (b),
        .m       (m),
        .b3      (b3),
        .m3      (m3),
        .acc_low (acc_low),
        .result  (result)
    );

endmodule

// File: verif/montgomery_sva.sv
`timescale 1ns/1ps

module montgomery_sva (
    input logic                          clk,
    input logic                          resetn,
    input logic                          start,
    input logic [mont_pkg::OP_WIDTH-1:0] a,
    input logic [mont_pkg::OP_WIDTH-1:0] b,
    input logic [mont_pkg::OP_WIDTH-1:0] m,
    input logic [mont_pkg::OP_WIDTH-1:0] result,
    input logic                          busy,
    input logic                          done
);
    import mont_pkg::*;

    int error_count = 0;

    logic [OP_WIDTH-1:0]   a_l;
    logic [OP_WIDTH-1:0]   b_l;
    logic [OP_WIDTH-1:0]   m_l;
    logic [2*OP_WIDTH-1:0] ab_mod;
    logic [2*OP_WIDTH-1:0] res_mod;

    // operands of the accepted start
    always_ff @(posedge clk) begin
        if (!resetn) begin
            a_l <= '0;
            b_l <= '0;
            m_l <= '0;
        end else if (start && !busy) begin
            a_l <= a;
            b_l <= b;
            m_l <= m;
        end
    end

    // a*b mod m against result*R mod m
    assign ab_mod  = ({{OP_WIDTH{1'b0}}, a_l} * {{OP_WIDTH{1'b0}}, b_l})
                     % {{OP_WIDTH{1'b0}}, m_l};
    assign res_mod = {result, {OP_WIDTH{1'b0}}} % {{OP_WIDTH{1'b0}}, m_l};

    a_identity: assert property (@(posedge clk) disable iff (!resetn)
        done |-> res_mod == ab_mod)
    else begin
        error_count++;
        $error("result does not satisfy the modular identity");
    end

    a_range: assert property (@(posedge clk) disable iff (!resetn)
        done |-> result < m_l)
    else begin
        error_count++;
        $error("result is not below the modulus");
    end

    a_latency: assert property (@(posedge clk) disable iff (!resetn)
        start && !busy |-> ##(OP_WIDTH+4) done)
    else begin
        error_count++;
        $error("done missing at the expected cycle");
    end

    // no early or stray done
    a_done_origin: assert property (@(posedge clk) disable iff (!resetn)
        $rose(done) |-> $past(busy, OP_WIDTH+3) && !$past(busy, OP_WIDTH+4))
    else begin
        error_count++;
        $error("done not tied to an accepted start");
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!resetn)
        done |=> !done)
    else begin
        error_count++;
        $error("done longer than one cycle");
    end

    a_busy_rise: assert property (@(posedge clk) disable iff (!resetn)
        start && !busy |=> busy)
    else begin
        error_count++;
        $error("busy did not rise after start");
    end

    a_busy_fall: assert property (@(posedge clk) disable iff (!resetn)
        $fell(busy) |-> $past(done))
    else begin
        error_count++;
        $error("busy fell without done");
    end

    a_done_busy: assert property (@(posedge clk) disable iff (!resetn)
        done |-> busy ##1 !busy)
    else begin
        error_count++;
        $error("busy did not fall with done");
    end

    a_reset_idle: assert property (@(posedge clk)
        $rose(resetn) |-> !busy && !done)
    else begin
        error_count++;
        $error("busy or done high out of reset");
    end

endmodule

bind montgomery_top montgomery_sva u_sva (.*);

// File: verif/tb_montgomery.sv
`timescale 1ns/1ps

module tb_montgomery;
    import mont_pkg::*;

    localparam int          NUM_RANDOM     = 20;
    localparam int          TIMEOUT_CYCLES = 2 * OP_WIDTH + 64;
    localparam logic [31:0] SEED           = 32'h4673;

    logic                clk;
    logic                resetn;
    logic                start;
    logic [OP_WIDTH-1:0] a;
    logic [OP_WIDTH-1:0] b;
    logic [OP_WIDTH-1:0] m;
    logic [OP_WIDTH-1:0] result;
    logic                busy;
    logic                done;
    logic [31:0]         rng_state;
    int                  tests_run;
    int                  tests_failed;

    montgomery_top uut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [OP_WIDTH-1:0] random_word();
        logic [OP_WIDTH-1:0] val;
        val = '0;
        for (int i = 0; i < OP_WIDTH / 32; i++) begin
            val = {val[OP_WIDTH-33:0], lcg_next()};
        end
        return val;
    endfunction

    // odd, full width modulus
    function automatic logic [OP_WIDTH-1:0] random_modulus();
        return random_word() | {1'b1, {(OP_WIDTH-2){1'b0}}, 1'b1};
    endfunction

    task automatic run_op(input string name, input logic [OP_WIDTH-1:0] a_v,
                          input logic [OP_WIDTH-1:0] b_v, input logic [OP_WIDTH-1:0] m_v,
                          input bit poke_start);
        logic [2*OP_WIDTH-1:0] m_wide;
        logic [2*OP_WIDTH-1:0] expected;
        logic [2*OP_WIDTH-1:0] actual;
        int                    cycles;
        bit                    ok;
        bit                    idle_ok;
        ok = 1'b1;
        idle_ok = 1'b1;
        cycles = 0;
        m_wide = {{OP_WIDTH{1'b0}}, m_v};
        a = a_v;
        b = b_v;
        m = m_v;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            // stray start halfway through the digit loop
            start = poke_start && (cycles == NUM_DIGITS);
            @(negedge clk);
            cycles++;
        end
        start = 1'b0;
        if (!done) begin
            $display("test %s timed out, no done within %0d cycles", name, TIMEOUT_CYCLES);
            ok = 1'b0;
        end else begin
            expected = ({{OP_WIDTH{1'b0}}, a_v} * {{OP_WIDTH{1'b0}}, b_v}) % m_wide;
            actual = {result, {OP_WIDTH{1'b0}}} % m_wide;
            if (actual != expected) begin
                $display("MISMATCH %s: expected %h actual %h", name,
                         expected[OP_WIDTH-1:0], actual[OP_WIDTH-1:0]);
                ok = 1'b0;
            end
            if (a_v == '0 && result != '0) begin
                $display("MISMATCH %s: expected %h actual %h", name, {OP_WIDTH{1'b0}}, result);
                ok = 1'b0;
            end
        end
        // must go idle and stay idle after done
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            if (busy || done) begin
                idle_ok = 1'b0;
            end
        end
        if (!idle_ok) begin
            $display("test %s: busy or done came back after done", name);
            ok = 1'b0;
        end
        tests_run++;
        if (!ok) begin
            tests_failed++;
        end
        $display("test %s: %s", name, ok ? "ok" : "fail");
    endtask

    initial begin
        logic [OP_WIDTH-1:0] m_r;
        string               name;
        clk = 1'b0;
        resetn = 1'b0;
        start = 1'b0;
        a = '0;
        b = '0;
        m = '0;
        rng_state = SEED;
        tests_run = 0;
        tests_failed = 0;
        repeat (16) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        if (busy || done) begin
            $display("busy or done high right after reset");
            tests_failed++;
        end
        m_r = random_modulus();
        run_op("zero_a", '0, random_word() % m_r, m_r, 1'b0);
        run_op("max_operands", m_r - 1'b1, m_r - 1'b1, m_r, 1'b0);
        run_op("unit_operands", 1, 1, m_r, 1'b0);
        run_op("start_while_busy", random_word() % m_r, random_word() % m_r, m_r, 1'b1);
        for (int t = 0; t < NUM_RANDOM; t++) begin
            m_r = random_modulus();
            name = $sformatf("random_%0d", t);
            run_op(name, random_word() % m_r, random_word() % m_r, m_r, 1'b0);
        end
        $display("tests run %0d, passed %0d, failed %0d, assertion errors %0d", tests_run,
                 tests_run - tests_failed, tests_failed, uut.u_sva.error_count);
        if (tests_failed == 0 && uut.u_sva.error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: sources.f
src/mont_pkg.sv
src/mont_ctrl.sv
src/multiple_precompute.sv
src/multiplier_shifter.sv
src/mont_accumulator.sv
src/montgomery_top.sv
verif/montgomery_sva.sv
verif/tb_montgomery.sv

// File: Bender.yml
package:
  name: montgomery_mult

sources:
  - src/mont_pkg.sv
  - src/mont_ctrl.sv
  - src/multiple_precompute.sv
  - src/multiplier_shifter.sv
  - src/mont_accumulator.sv
  - src/montgomery_top.sv
  - target: test
    files:
      - verif/montgomery_sva.sv
      - verif/tb_montgomery.sv
